/* Bender.yml */
package:
  name: state_manager

sources:
  - logic/smPkg.sv
  - logic/cmdDecode.sv
  - logic/fetchPlanner.sv
  - logic/saveArbiter.sv
  - logic/stepSequencer.sv
  - logic/stateManager.sv
  - target: test
    files:
      - tb/stateManagerTb.sv

/* logic/cmdDecode.sv */
`timescale 1ns/1ns

module cmdDecode (
  input  logic [smPkg::CmdWidth-1:0] command,
  input  logic [smPkg::DataWidth-1:0] cond,
  output smPkg::cmdFields_t fields,
  output logic condTrue
);

  // register numbers, one nibble each
  logic [smPkg::RegNumWidth-1:0] numSrc1;
  logic [smPkg::RegNumWidth-1:0] numSrc0;
  logic [smPkg::RegNumWidth-1:0] numDst;
  logic [smPkg::RegNumWidth-1:0] numCond;

  // pointer bits, same operand order
  logic [3:0] ptrBits;

  // flag pairs, same operand order
  logic [7:0] flagBits;

  assign numSrc1 = command[3:0];
  assign numSrc0 = command[7:4];
  assign numDst = command[11:8];
  assign numCond = command[15:12];
  assign ptrBits = command[19:16];
  assign flagBits = command[27:20];
  // top nibble carries the opcode, not ours

  assign fields.src1 = '{
    regNum: numSrc1,
    isPtr: ptrBits[0],
    flags: flagBits[1:0]
  };
  assign fields.src0 = '{
    regNum: numSrc0,
    isPtr: ptrBits[1],
    flags: flagBits[3:2]
  };
  assign fields.dst = '{
    regNum: numDst,
    isPtr: ptrBits[2],
    flags: flagBits[5:4]
  };
  assign fields.cond = '{
    regNum: numCond,
    isPtr: ptrBits[3],
    flags: flagBits[7:6]
  };

  // any nonzero condition value counts as true
  assign condTrue = |cond;

endmodule

/* logic/fetchPlanner.sv */
`timescale 1ns/1ns

module fetchPlanner (
  input  smPkg::cmdFields_t fields,
  input  smPkg::readFlags_t reads,
  input  logic condTrue,
  input  logic ipSave,
  output smPkg::fetchNext_t fetchNext
);

  // earlier operand already latched with the same register
  function automatic logic fwd(
    smPkg::operand_t op,
    smPkg::operand_t earlier,
    logic latched
  );
    return smPkg::opRead(earlier) && (op.regNum == earlier.regNum) && latched;
  endfunction

  logic fillSrc1;
  logic fillSrc0;
  logic fillDst;
  logic ipJump;

  // plan from each phase onward
  logic [smPkg::StateWidth-1:0] dstStep;
  logic [smPkg::StateWidth-1:0] fromSrc0;
  logic [smPkg::StateWidth-1:0] fromSrc1;

  // src1 can only forward from cond
  assign fillSrc1 = smPkg::opTouchesIp(fields.src1)
                 || fwd(fields.src1, fields.cond, reads.isCndRead);

  // src0 forwards from cond or src1
  assign fillSrc0 = smPkg::opTouchesIp(fields.src0)
                 || fwd(fields.src0, fields.cond, reads.isCndRead)
                 || fwd(fields.src0, fields.src1, reads.isS1Read);

  // dst checks all three sources
  assign fillDst = smPkg::opTouchesIp(fields.dst)
                || fwd(fields.dst, fields.cond, reads.isCndRead)
                || fwd(fields.dst, fields.src1, reads.isS1Read)
                || fwd(fields.dst, fields.src0, reads.isS0Read);

  // dst only fetched as a pointer target
  always_comb begin
    if (fields.dst.isPtr) begin
      dstStep = fillDst ? smPkg::StFillDstP : smPkg::StReadDst;
    end else begin
      dstStep = smPkg::StAluBegin;
    end
  end

  always_comb begin
    if (smPkg::opRead(fields.src0)) begin
      fromSrc0 = fillSrc0 ? smPkg::StFillSrc0 : smPkg::StReadSrc0;
    end else begin
      fromSrc0 = dstStep;
    end
  end

  always_comb begin
    if (smPkg::opRead(fields.src1)) begin
      fromSrc1 = fillSrc1 ? smPkg::StFillSrc1 : smPkg::StReadSrc1;
    end else begin
      fromSrc1 = dstStep;
    end
  end

  // failed condition with IP free to save, so step IP instead of jumping
  assign ipJump = ipSave && !condTrue;

  // afterPrep starts past cond
  // the sequencer puts the cond step in front itself since cond never forwards,
  // and it also serves as the read part once IP is written
  assign fetchNext.afterPrep = fromSrc1;
  assign fetchNext.afterCond = ipJump ? smPkg::StWriteRegIp : fromSrc1;
  assign fetchNext.afterSrc1 = fromSrc0;
  assign fetchNext.afterSrc0 = dstStep;

endmodule

/* logic/saveArbiter.sv */
`timescale 1ns/1ns

module saveArbiter (
  input  smPkg::cmdFields_t fields,
  input  logic condTrue,
  output smPkg::saveFlags_t saves,
  output smPkg::wbNext_t wbNext
);

  // op survives unless a later save hits the same register
  function automatic logic notShadowed(
    smPkg::operand_t op,
    smPkg::operand_t other,
    logic otherSaved
  );
    return (other.regNum != op.regNum) || !otherSaved;
  endfunction

  logic condPass;
  logic dstSave;
  logic wrCond;
  logic wrSrc1;
  logic wrSrc0;

  assign wrCond = smPkg::opWritten(fields.cond);
  assign wrSrc1 = smPkg::opWritten(fields.src1);
  assign wrSrc0 = smPkg::opWritten(fields.src0);

  // unused cond slot means always execute
  assign condPass = (smPkg::opRead(fields.cond) && condTrue)
                 || !smPkg::opRead(fields.cond);

  assign dstSave = smPkg::opRead(fields.dst) && condPass;

  assign saves.dstSave = dstSave;
  assign saves.dstPtrSave = !smPkg::opRead(fields.dst) && fields.dst.isPtr && condPass;

  // dst wins over everything, then src0, then src1
  assign saves.condSave = wrCond
                       && notShadowed(fields.cond, fields.dst, dstSave)
                       && notShadowed(fields.cond, fields.src1, wrSrc1)
                       && notShadowed(fields.cond, fields.src0, wrSrc0);
  assign saves.src1Save = wrSrc1
                       && notShadowed(fields.src1, fields.dst, dstSave)
                       && notShadowed(fields.src1, fields.src0, wrSrc0);
  assign saves.src0Save = wrSrc0
                       && notShadowed(fields.src0, fields.dst, dstSave);

  // IP auto-increment only if no operand writes IP
  assign saves.ipSave = !(
      (smPkg::opTouchesIp(fields.dst) && dstSave)
   || (smPkg::opTouchesIp(fields.cond) && wrCond)
   || (smPkg::opTouchesIp(fields.src1) && wrSrc1)
   || (smPkg::opTouchesIp(fields.src0) && wrSrc0)
  );

  // write-back chain, built from the tail
  assign wbNext.afterSrc1 = saves.src0Save ? smPkg::StWriteSrc0 : smPkg::StFinishBegin;
  assign wbNext.afterCond = saves.src1Save ? smPkg::StWriteSrc1 : wbNext.afterSrc1;
  assign wbNext.afterDst = saves.condSave ? smPkg::StWriteCond : wbNext.afterCond;

  // pointer write first, then the plain write if dst is also written
  assign wbNext.afterDstP = smPkg::opWritten(fields.dst) ? smPkg::StWriteDst
                                                         : wbNext.afterDst;

  always_comb begin
    if (dstSave) begin
      wbNext.afterPrep = fields.dst.isPtr ? smPkg::StWriteDstP : smPkg::StWriteDst;
    end else if (saves.dstPtrSave) begin
      wbNext.afterPrep = smPkg::StWriteDstP;
    end else begin
      wbNext.afterPrep = wbNext.afterDst;
    end
  end

endmodule

/* logic/smPkg.sv */
package smPkg;

  // widths
  localparam int RegNumWidth = 4;
  localparam int DataWidth = 32;
  localparam int StateWidth = 5;
  localparam int CmdWidth = 32;

  // instruction pointer lives in the top register
  localparam logic [RegNumWidth-1:0] RegIp = 4'd15;

  // start-up and command fetch
  localparam logic [StateWidth-1:0] StWaitForStart = 5'd0;
  localparam logic [StateWidth-1:0] StStartBegin = 5'd1;
  localparam logic [StateWidth-1:0] StReadMemSize1 = 5'd2;
  localparam logic [StateWidth-1:0] StAfterMemSizeRead = 5'd3;
  localparam logic [StateWidth-1:0] StStartReadCmd = 5'd4;
  localparam logic [StateWidth-1:0] StStartReadCmdP = 5'd5;
  localparam logic [StateWidth-1:0] StPreexecute = 5'd6;
  localparam logic [StateWidth-1:0] StWriteRegIp = 5'd7;
  // operand fetch
  localparam logic [StateWidth-1:0] StReadCond = 5'd8;
  localparam logic [StateWidth-1:0] StFillCond = 5'd9;
  localparam logic [StateWidth-1:0] StReadCondP = 5'd10;
  localparam logic [StateWidth-1:0] StReadSrc1 = 5'd11;
  localparam logic [StateWidth-1:0] StFillSrc1 = 5'd12;
  localparam logic [StateWidth-1:0] StReadSrc1P = 5'd13;
  localparam logic [StateWidth-1:0] StReadSrc0 = 5'd14;
  localparam logic [StateWidth-1:0] StFillSrc0 = 5'd15;
  localparam logic [StateWidth-1:0] StReadSrc0P = 5'd16;
  localparam logic [StateWidth-1:0] StReadDst = 5'd17;
  localparam logic [StateWidth-1:0] StFillDstP = 5'd18;
  // execute, write-back, finish
  localparam logic [StateWidth-1:0] StAluBegin = 5'd19;
  localparam logic [StateWidth-1:0] StAluResults = 5'd20;
  localparam logic [StateWidth-1:0] StWritePrep = 5'd21;
  localparam logic [StateWidth-1:0] StWriteDst = 5'd22;
  localparam logic [StateWidth-1:0] StWriteDstP = 5'd23;
  localparam logic [StateWidth-1:0] StWriteCond = 5'd24;
  localparam logic [StateWidth-1:0] StWriteSrc1 = 5'd25;
  localparam logic [StateWidth-1:0] StWriteSrc0 = 5'd26;
  localparam logic [StateWidth-1:0] StFinishBegin = 5'd27;
  localparam logic [StateWidth-1:0] StFinishEnd = 5'd28;

  // one operand slot of the command word
  typedef struct packed {
    logic [RegNumWidth-1:0] regNum;
    logic isPtr;
    logic [1:0] flags;
  } operand_t;

  typedef struct packed {
    operand_t src1;
    operand_t src0;
    operand_t dst;
    operand_t cond;
  } cmdFields_t;

  // value already sitting in the bus latch
  typedef struct packed {
    logic isCndRead;
    logic isS1Read;
    logic isS0Read;
  } readFlags_t;

  typedef struct packed {
    logic ipSave;
    logic dstSave;
    logic dstPtrSave;
    logic condSave;
    logic src1Save;
    logic src0Save;
  } saveFlags_t;

  typedef struct packed {
    logic [StateWidth-1:0] afterPrep;
    logic [StateWidth-1:0] afterCond;
    logic [StateWidth-1:0] afterSrc1;
    logic [StateWidth-1:0] afterSrc0;
  } fetchNext_t;

  typedef struct packed {
    logic [StateWidth-1:0] afterPrep;
    logic [StateWidth-1:0] afterDstP;
    logic [StateWidth-1:0] afterDst;
    logic [StateWidth-1:0] afterCond;
    logic [StateWidth-1:0] afterSrc1;
  } wbNext_t;

  // flags 11 means the slot is unused
  function automatic logic opRead(operand_t op);
    return !(&op.flags);
  endfunction

  // flags 01 or 10 mean a write-back
  function automatic logic opWritten(operand_t op);
    return ^op.flags;
  endfunction

  function automatic logic opTouchesIp(operand_t op);
    return op.regNum == RegIp;
  endfunction

  // sequential successor, finish wraps back to idle
  function automatic logic [StateWidth-1:0] nextCode(logic [StateWidth-1:0] s);
    return (s == StFinishEnd) ? StWaitForStart : s + StateWidth'(1);
  endfunction

endpackage

/* logic/stateManager.sv */
`timescale 1ns/1ns

module stateManager (
  input  logic next_state,
  input  logic rst,
  input  logic [smPkg::CmdWidth-1:0] command,
  input  logic [smPkg::DataWidth-1:0] cond,
  input  smPkg::readFlags_t reads,
  input  logic threadEscape,
  output logic [smPkg::StateWidth-1:0] state,
  output logic nextStateDn,
  output smPkg::saveFlags_t saves
);

  smPkg::cmdFields_t fields;
  logic condTrue;
  smPkg::fetchNext_t fetchNext;
  smPkg::wbNext_t wbNext;

  // command word split into operand slots
  cmdDecode uCmdDecode (
    .command(command),
    .cond(cond),
    .fields(fields),
    .condTrue(condTrue)
  );

  // save permissions and write-back order
  saveArbiter uSaveArbiter (
    .fields(fields),
    .condTrue(condTrue),
    .saves(saves),
    .wbNext(wbNext)
  );

  // read or fill choice per fetch phase
  fetchPlanner uFetchPlanner (
    .fields(fields),
    .reads(reads),
    .condTrue(condTrue),
    .ipSave(saves.ipSave),
    .fetchNext(fetchNext)
  );

  stepSequencer uStepSequencer (
    .next_state(next_state),
    .rst(rst),
    .threadEscape(threadEscape),
    .fields(fields),
    .condTrue(condTrue),
    .ipSave(saves.ipSave),
    .fetchNext(fetchNext),
    .wbNext(wbNext),
    .state(state),
    .nextStateDn(nextStateDn)
  );

endmodule

/* logic/stepSequencer.sv */
`timescale 1ns/1ns

module stepSequencer (
  input  logic next_state,
  input  logic rst,
  input  logic threadEscape,
  input  smPkg::cmdFields_t fields,
  input  logic condTrue,
  input  logic ipSave,
  input  smPkg::fetchNext_t fetchNext,
  input  smPkg::wbNext_t wbNext,
  output logic [smPkg::StateWidth-1:0] state,
  output logic nextStateDn
);

  logic [smPkg::StateWidth-1:0] stateNext;
  logic [smPkg::StateWidth-1:0] condStep;
  logic [smPkg::StateWidth-1:0] fetchEntry;
  logic [smPkg::StateWidth-1:0] afterCondStep;

  // per-command progress
  logic condDone;
  logic ipWritten;

  logic ipJump;

  // cond is never forwarded, only IP makes it a fill
  assign condStep = smPkg::opTouchesIp(fields.cond) ? smPkg::StFillCond
                                                    : smPkg::StReadCond;

  // fetch from prep or after the IP write
  // skip cond once it has been handled
  assign fetchEntry = (smPkg::opRead(fields.cond) && !condDone) ? condStep
                                                               : fetchNext.afterPrep;

  // IP write after a failed condition, first time only
  assign ipJump = (fetchNext.afterCond == smPkg::StWriteRegIp) && !condTrue && !ipWritten;

  assign afterCondStep = ipJump ? smPkg::StWriteRegIp : fetchNext.afterPrep;

  always_comb begin
    stateNext = smPkg::nextCode(state);
    if (threadEscape) begin
      // escape lets finish run out, everything else jumps to finish
      if (state != smPkg::StFinishBegin && state != smPkg::StFinishEnd) begin
        stateNext = smPkg::StFinishBegin;
      end
    end else begin
      case (state)
        smPkg::StPreexecute: begin
          stateNext = ipSave ? smPkg::StWriteRegIp : fetchEntry;
        end
        smPkg::StWriteRegIp: begin
          stateNext = fetchEntry;
        end
        smPkg::StReadCond, smPkg::StFillCond: begin
          stateNext = fields.cond.isPtr ? smPkg::StReadCondP : afterCondStep;
        end
        smPkg::StReadCondP: begin
          stateNext = afterCondStep;
        end
        smPkg::StReadSrc1, smPkg::StFillSrc1: begin
          stateNext = fields.src1.isPtr ? smPkg::StReadSrc1P : fetchNext.afterSrc1;
        end
        smPkg::StReadSrc1P: begin
          stateNext = fetchNext.afterSrc1;
        end
        smPkg::StReadSrc0, smPkg::StFillSrc0: begin
          stateNext = fields.src0.isPtr ? smPkg::StReadSrc0P : fetchNext.afterSrc0;
        end
        smPkg::StReadSrc0P: begin
          stateNext = fetchNext.afterSrc0;
        end
        smPkg::StReadDst, smPkg::StFillDstP: begin
          stateNext = smPkg::StAluBegin;
        end
        // write-back chain from the arbiter
        smPkg::StWritePrep: begin
          stateNext = wbNext.afterPrep;
        end
        smPkg::StWriteDstP: begin
          stateNext = wbNext.afterDstP;
        end
        smPkg::StWriteDst: begin
          stateNext = wbNext.afterDst;
        end
        smPkg::StWriteCond: begin
          stateNext = wbNext.afterCond;
        end
        smPkg::StWriteSrc1: begin
          stateNext = wbNext.afterSrc1;
        end
        default: begin
          stateNext = smPkg::nextCode(state);
        end
      endcase
    end
  end

  // one step per edge, ack toggles every time
  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      state <= smPkg::StWaitForStart;
      nextStateDn <= 1'b0;
      condDone <= 1'b0;
      ipWritten <= 1'b0;
    end else begin
      state <= stateNext;
      nextStateDn <= ~nextStateDn;
      case (state)
        // fresh command
        smPkg::StWaitForStart: begin
          condDone <= 1'b0;
          ipWritten <= 1'b0;
        end
        smPkg::StReadCond, smPkg::StFillCond: begin
          condDone <= 1'b1;
        end
        smPkg::StWriteRegIp: begin
          ipWritten <= 1'b1;
        end
        default: begin
          condDone <= condDone;
        end
      endcase
    end
  end

endmodule

/* tb/stateManagerTb.sv */
`timescale 1ns/1ns

module stateManagerTb;

  // longest command path plus start-up, in steps
  localparam int NumCmds = 30;
  localparam int MaxSteps = 40;
  localparam int WatchdogNs = (10 + NumCmds * MaxSteps) * 20 + 2000;

  logic next_state;
  logic rst;
  logic [31:0] command;
  logic [31:0] cond;
  smPkg::readFlags_t reads;
  logic threadEscape;
  logic [4:0] state;
  logic nextStateDn;
  smPkg::saveFlags_t saves;

  int errCount;
  int unsigned seedDummy;
  logic ackExp;
  // step model
  logic [4:0] curM;
  logic condDoneM;
  logic ipWrittenM;
  logic [31:0] visited;

  stateManager uut (
    .next_state(next_state),
    .rst(rst),
    .command(command),
    .cond(cond),
    .reads(reads),
    .threadEscape(threadEscape),
    .state(state),
    .nextStateDn(nextStateDn),
    .saves(saves)
  );

  initial begin
    next_state = 1'b0;
    forever #10 next_state = ~next_state;
  end

  // 0 src1, 1 src0, 2 dst, 3 cond
  function automatic smPkg::operand_t opAt(int idx);
    smPkg::operand_t op;
    op.regNum = command[idx*4 +: 4];
    op.isPtr = command[16 + idx];
    op.flags = command[20 + 2*idx +: 2];
    return op;
  endfunction

  function automatic logic isRead(smPkg::operand_t op);
    return op.flags != 2'b11;
  endfunction

  function automatic logic isWritten(smPkg::operand_t op);
    return op.flags == 2'b01 || op.flags == 2'b10;
  endfunction

  function automatic logic isIp(smPkg::operand_t op);
    return op.regNum == 4'd15;
  endfunction

  // {ip, dst, dstPtr, cond, src1, src0}
  function automatic logic [5:0] expectSaves();
    smPkg::operand_t s1, s0, d, c;
    logic pass, dS, dP, cS, s1S, s0S, ipS;
    s1 = opAt(0);
    s0 = opAt(1);
    d = opAt(2);
    c = opAt(3);
    pass = !isRead(c) || (cond != 0);
    dS = isRead(d) && pass;
    dP = !isRead(d) && d.isPtr && pass;
    cS = isWritten(c) && !(d.regNum == c.regNum && dS)
      && !(s1.regNum == c.regNum && isWritten(s1))
      && !(s0.regNum == c.regNum && isWritten(s0));
    s1S = isWritten(s1) && !(d.regNum == s1.regNum && dS)
       && !(s0.regNum == s1.regNum && isWritten(s0));
    s0S = isWritten(s0) && !(d.regNum == s0.regNum && dS);
    ipS = !((isIp(d) && dS) || (isIp(c) && isWritten(c))
         || (isIp(s1) && isWritten(s1)) || (isIp(s0) && isWritten(s0)));
    return {ipS, dS, dP, cS, s1S, s0S};
  endfunction

  // value already latched by an earlier read of the same register
  function automatic logic forwards(smPkg::operand_t op, smPkg::operand_t src, logic latched);
    return isRead(src) && latched && op.regNum == src.regNum;
  endfunction

  function automatic logic [4:0] dstStep();
    smPkg::operand_t d;
    logic fill;
    d = opAt(2);
    fill = isIp(d) || forwards(d, opAt(3), reads.isCndRead)
        || forwards(d, opAt(0), reads.isS1Read) || forwards(d, opAt(1), reads.isS0Read);
    if (!d.isPtr) return smPkg::StAluBegin;
    return fill ? smPkg::StFillDstP : smPkg::StReadDst;
  endfunction

  function automatic logic [4:0] fromSrc0();
    smPkg::operand_t s0;
    logic fill;
    s0 = opAt(1);
    fill = isIp(s0) || forwards(s0, opAt(3), reads.isCndRead)
        || forwards(s0, opAt(0), reads.isS1Read);
    if (!isRead(s0)) return dstStep();
    return fill ? smPkg::StFillSrc0 : smPkg::StReadSrc0;
  endfunction

  function automatic logic [4:0] fromSrc1();
    smPkg::operand_t s1;
    logic fill;
    s1 = opAt(0);
    fill = isIp(s1) || forwards(s1, opAt(3), reads.isCndRead);
    if (!isRead(s1)) return fromSrc0();
    return fill ? smPkg::StFillSrc1 : smPkg::StReadSrc1;
  endfunction

  // write chain tail, k is the first slot still open
  function automatic logic [4:0] tailFrom(int k);
    logic [5:0] sv;
    sv = expectSaves();
    if (k <= 0 && sv[2]) return smPkg::StWriteCond;
    if (k <= 1 && sv[1]) return smPkg::StWriteSrc1;
    if (k <= 2 && sv[0]) return smPkg::StWriteSrc0;
    return smPkg::StFinishBegin;
  endfunction

  function automatic logic [4:0] modelNext();
    logic [5:0] sv;
    logic [4:0] entry, afterCond, seq;
    smPkg::operand_t c;
    smPkg::operand_t s1;
    smPkg::operand_t s0;
    smPkg::operand_t d;
    sv = expectSaves();
    c = opAt(3);
    s1 = opAt(0);
    s0 = opAt(1);
    d = opAt(2);
    seq = (curM == smPkg::StFinishEnd) ? smPkg::StWaitForStart : curM + 5'd1;
    entry = (isRead(c) && !condDoneM)
          ? (isIp(c) ? smPkg::StFillCond : smPkg::StReadCond) : fromSrc1();
    afterCond = (sv[5] && cond == 0 && !ipWrittenM) ? smPkg::StWriteRegIp : fromSrc1();
    if (threadEscape) begin
      if (curM == smPkg::StFinishBegin || curM == smPkg::StFinishEnd) return seq;
      return smPkg::StFinishBegin;
    end
    case (curM)
      smPkg::StPreexecute: return sv[5] ? smPkg::StWriteRegIp : entry;
      smPkg::StWriteRegIp: return entry;
      smPkg::StReadCond, smPkg::StFillCond: return c.isPtr ? smPkg::StReadCondP : afterCond;
      smPkg::StReadCondP: return afterCond;
      smPkg::StReadSrc1, smPkg::StFillSrc1: return s1.isPtr ? smPkg::StReadSrc1P : fromSrc0();
      smPkg::StReadSrc1P: return fromSrc0();
      smPkg::StReadSrc0, smPkg::StFillSrc0: return s0.isPtr ? smPkg::StReadSrc0P : dstStep();
      smPkg::StReadSrc0P: return dstStep();
      smPkg::StReadDst, smPkg::StFillDstP: return smPkg::StAluBegin;
      smPkg::StWritePrep: begin
        if (sv[4]) return d.isPtr ? smPkg::StWriteDstP : smPkg::StWriteDst;
        if (sv[3]) return smPkg::StWriteDstP;
        return tailFrom(0);
      end
      smPkg::StWriteDstP: return isWritten(d) ? smPkg::StWriteDst : tailFrom(0);
      smPkg::StWriteDst: return tailFrom(0);
      smPkg::StWriteCond: return tailFrom(1);
      smPkg::StWriteSrc1: return tailFrom(2);
      default: return seq;
    endcase
  endfunction

  task automatic checkNow();
    if (state !== curM) begin
      $display("Mismatch state: expected %h, got %h", curM, state);
      errCount++;
    end
    if (nextStateDn !== ackExp) begin
      $display("Mismatch nextStateDn: expected %h, got %h", ackExp, nextStateDn);
      errCount++;
    end
  endtask

  // one edge, esc is driven for the following edge
  task automatic step(input logic esc);
    logic [4:0] exp;
    exp = modelNext();
    if (curM == smPkg::StWaitForStart) begin
      condDoneM = 1'b0;
      ipWrittenM = 1'b0;
    end
    if (curM == smPkg::StReadCond || curM == smPkg::StFillCond) condDoneM = 1'b1;
    if (curM == smPkg::StWriteRegIp) ipWrittenM = 1'b1;
    @(posedge next_state);
    threadEscape <= esc;
    ackExp = ~ackExp;
    curM = exp;
    visited[exp] = 1'b1;
    @(negedge next_state);
    checkNow();
  endtask

  // new inputs go out on the edge that leaves idle
  task automatic startCommand(input logic [31:0] cmd, input logic [31:0] cnd,
                              input logic [2:0] rd);
    if (curM != smPkg::StWaitForStart) begin
      $display("Command started while the sequencer was not idle");
      errCount++;
    end
    visited = '0;
    condDoneM = 1'b0;
    ipWrittenM = 1'b0;
    @(posedge next_state);
    command <= cmd;
    cond <= cnd;
    reads <= rd;
    ackExp = ~ackExp;
    curM = smPkg::StStartBegin;
    @(negedge next_state);
    checkNow();
    repeat (5) step(1'b0);
    if (saves !== expectSaves()) begin
      $display("Mismatch saves: expected %h, got %h", expectSaves(), saves);
      errCount++;
    end
  endtask

  task automatic runCommand(input logic [31:0] cmd, input logic [31:0] cnd,
                            input logic [2:0] rd);
    int n;
    n = 0;
    startCommand(cmd, cnd, rd);
    while (curM != smPkg::StWaitForStart && n < MaxSteps) begin
      step(1'b0);
      n++;
    end
    if (curM != smPkg::StWaitForStart) begin
      $display("Command did not return to idle within %0d steps", MaxSteps);
      errCount++;
    end
  endtask

  // flags and ptr in operand order cond, dst, src0, src1
  function automatic logic [31:0] makeCmd(logic [3:0] c, logic [3:0] d, logic [3:0] s0,
                                          logic [3:0] s1, logic [3:0] ptr, logic [7:0] fl);
    return {4'h0, fl, ptr, c, d, s0, s1};
  endfunction

  task automatic expectVisited(input logic [4:0] st, input logic want);
    if (visited[st] !== want) begin
      $display("Step %h was %s on this command", st, want ? "not reached" : "reached");
      errCount++;
    end
  endtask

  task automatic startupTest();
    checkNow();
    runCommand(makeCmd(4'd1, 4'd2, 4'd3, 4'd4, 4'b0000, 8'hff), 32'd0, 3'b000);
  endtask

  task automatic fullFetchTest();
    runCommand(makeCmd(4'd1, 4'd2, 4'd3, 4'd4, 4'b0100, 8'h00), 32'd5, 3'b000);
    expectVisited(smPkg::StReadCond, 1'b1);
    expectVisited(smPkg::StReadSrc1, 1'b1);
    expectVisited(smPkg::StReadSrc0, 1'b1);
    expectVisited(smPkg::StReadDst, 1'b1);
    expectVisited(smPkg::StWriteDstP, 1'b1);
    // every pointer bit set inserts all P steps
    runCommand(makeCmd(4'd1, 4'd2, 4'd3, 4'd4, 4'b1111, 8'h00), 32'd9, 3'b000);
    expectVisited(smPkg::StReadCondP, 1'b1);
    expectVisited(smPkg::StReadSrc1P, 1'b1);
    expectVisited(smPkg::StReadSrc0P, 1'b1);
  endtask

  task automatic forwardingTest();
    runCommand(makeCmd(4'd3, 4'd2, 4'd15, 4'd3, 4'b0000, 8'h00), 32'd1, 3'b100);
    expectVisited(smPkg::StFillSrc1, 1'b1);
    expectVisited(smPkg::StFillSrc0, 1'b1);
  endtask

  task automatic ipWriteTest();
    runCommand(makeCmd(4'd1, 4'd2, 4'd3, 4'd4, 4'b0000, 8'hff), 32'd0, 3'b000);
    expectVisited(smPkg::StWriteRegIp, 1'b1);
    // src0 writes IP, so no automatic IP step
    runCommand(makeCmd(4'd1, 4'd2, 4'd15, 4'd4, 4'b0000, 8'h04), 32'd0, 3'b000);
    expectVisited(smPkg::StWriteRegIp, 1'b0);
    expectVisited(smPkg::StReadCond, 1'b1);
    expectVisited(smPkg::StFillSrc0, 1'b1);
  endtask

  task automatic randomSavesTest();
    logic [7:0] fl;
    logic [31:0] cnd;
    for (int i = 0; i < 20; i++) begin
      // src1 kept in use
      fl = {2'($urandom_range(3)), 2'($urandom_range(3)), 2'($urandom_range(3)),
            2'($urandom_range(2))};
      cnd = $urandom_range(1) ? $urandom : 32'd0;
      runCommand(makeCmd(4'($urandom_range(15)), 4'($urandom_range(15)),
                         4'($urandom_range(15)), 4'($urandom_range(15)),
                         4'($urandom_range(15)), fl), cnd, 3'($urandom_range(7)));
    end
  endtask

  task automatic escapeTest();
    startCommand(makeCmd(4'd1, 4'd2, 4'd3, 4'd4, 4'b0000, 8'h00), 32'd1, 3'b000);
    // IP step, then cond read with escape raised
    step(1'b0);
    step(1'b1);
    step(1'b1);
    if (state !== smPkg::StFinishBegin) begin
      $display("Mismatch state: expected %h, got %h", smPkg::StFinishBegin, state);
      errCount++;
    end
    step(1'b1);
    step(1'b0);
    if (state !== smPkg::StWaitForStart) begin
      $display("Mismatch state: expected %h, got %h", smPkg::StWaitForStart, state);
      errCount++;
    end
  endtask

  initial begin
    #(WatchdogNs);
    $display("Timeout: the run did not complete in the expected time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seedDummy = $urandom(32'hf4f2);
    errCount = 0;
    rst = 1'b1;
    command = '0;
    cond = '0;
    reads = '0;
    threadEscape = 1'b0;
    ackExp = 1'b0;
    curM = smPkg::StWaitForStart;
    condDoneM = 1'b0;
    ipWrittenM = 1'b0;
    visited = '0;
    repeat (10) @(posedge next_state);
    rst <= 1'b0;
    @(negedge next_state);
    startupTest();
    fullFetchTest();
    forwardingTest();
    ipWriteTest();
    randomSavesTest();
    escapeTest();
    $display("Errors: %0d", errCount);
    if (errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/smPkg.sv
logic/cmdDecode.sv
logic/fetchPlanner.sv
logic/saveArbiter.sv
logic/stepSequencer.sv
logic/stateManager.sv
tb/stateManagerTb.sv
